// ==== build.f ====
common/mips_pkg.sv
common/ex_ctrl_if.sv
execute/alu_control.sv
execute/alu.sv
execute/ex_stage.sv
hdl/forward_unit.sv
hdl/ex_top.sv
tests/tb_ex_top.sv

// ==== common/ex_ctrl_if.sv ====
`timescale 1ns/1ns

// control flags that follow an instruction from execute into memory and writeback.
interface ex_ctrl_if;

    logic valid;
    logic reg_write;
    logic mem_to_reg;
    logic mem_read;
    logic mem_write;

    modport stage_in (
        input valid, reg_write, mem_to_reg, mem_read, mem_write
    );

    modport stage_out (
        output valid, reg_write, mem_to_reg, mem_read, mem_write
    );

    // the forward unit only needs to know whether the latched slot writes a register.
    modport monitor (
        input valid, reg_write
    );

endinterface

// ==== common/mips_pkg.sv ====
package mips_pkg;

    localparam int NB_DATA   = 32;
    localparam int NB_REG    = 5;
    localparam int NB_ALU_OP = 3;
    localparam int NB_FUNCT  = 6;
    localparam int NB_SHAMT  = 5;

    typedef logic [NB_DATA-1:0]   data_t;
    typedef logic [NB_REG-1:0]    reg_addr_t;
    typedef logic [NB_ALU_OP-1:0] alu_op_t;
    typedef logic [NB_FUNCT-1:0]  funct_t;

    // register 0 is hardwired to zero and never forwarded.
    localparam reg_addr_t REG_ZERO = '0;

    // alu class as produced by decode.
    localparam alu_op_t OP_ADD     = 3'd0;
    localparam alu_op_t OP_SUB     = 3'd1;
    localparam alu_op_t OP_RTYPE   = 3'd2;
    localparam alu_op_t OP_ANDI    = 3'd3;
    localparam alu_op_t OP_ORI     = 3'd4;
    localparam alu_op_t OP_SLTI    = 3'd5;
    localparam alu_op_t OP_LUI     = 3'd6;
    localparam alu_op_t OP_INVALID = 3'd7;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_ctrl_e;

    localparam funct_t F_ADD = 6'h20;
    localparam funct_t F_SUB = 6'h22;
    localparam funct_t F_AND = 6'h24;
    localparam funct_t F_OR  = 6'h25;
    localparam funct_t F_XOR = 6'h26;
    localparam funct_t F_NOR = 6'h27;
    localparam funct_t F_SLT = 6'h2A;
    localparam funct_t F_SLL = 6'h00;
    localparam funct_t F_SRL = 6'h02;

endpackage

// ==== execute/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  mips_pkg::data_t          i_a,
    input  mips_pkg::data_t          i_b,
    input  logic [mips_pkg::NB_SHAMT-1:0] i_shamt,
    input  mips_pkg::alu_ctrl_e      i_alu_ctrl,
    output mips_pkg::data_t          o_result,
    output logic                     o_zero
);

    import mips_pkg::*;

    always_comb begin
        case (i_alu_ctrl)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_XOR: o_result = i_a ^ i_b;
            ALU_NOR: o_result = ~(i_a | i_b);
            // set on less than compares as two's complement.
            ALU_SLT: o_result = data_t'($signed(i_a) < $signed(i_b));
            // shifts act on the rt operand, which arrives on port b.
            ALU_SLL: o_result = i_b << i_shamt;
            ALU_SRL: o_result = i_b >> i_shamt;
            ALU_LUI: o_result = i_b << 16;
            default: o_result = i_a + i_b;
        endcase
    end

    // beq subtracts the operands, so a zero result means they are equal.
    assign o_zero = (o_result == '0);

endmodule

// ==== execute/alu_control.sv ====
`timescale 1ns/1ns

module alu_control (
    input  logic                i_valid,
    input  mips_pkg::alu_op_t   i_alu_op,
    input  mips_pkg::funct_t    i_funct,
    output mips_pkg::alu_ctrl_e o_alu_ctrl
);

    import mips_pkg::*;

    always_comb begin
        case (i_alu_op)
            OP_ADD:   o_alu_ctrl = ALU_ADD;
            OP_SUB:   o_alu_ctrl = ALU_SUB;
            OP_ANDI:  o_alu_ctrl = ALU_AND;
            OP_ORI:   o_alu_ctrl = ALU_OR;
            OP_SLTI:  o_alu_ctrl = ALU_SLT;
            OP_LUI:   o_alu_ctrl = ALU_LUI;
            OP_RTYPE: begin
                case (i_funct)
                    F_ADD:   o_alu_ctrl = ALU_ADD;
                    F_SUB:   o_alu_ctrl = ALU_SUB;
                    F_AND:   o_alu_ctrl = ALU_AND;
                    F_OR:    o_alu_ctrl = ALU_OR;
                    F_XOR:   o_alu_ctrl = ALU_XOR;
                    F_NOR:   o_alu_ctrl = ALU_NOR;
                    F_SLT:   o_alu_ctrl = ALU_SLT;
                    F_SLL:   o_alu_ctrl = ALU_SLL;
                    F_SRL:   o_alu_ctrl = ALU_SRL;
                    // unknown funct codes fall back to add.
                    default: o_alu_ctrl = ALU_ADD;
                endcase
            end
            default:  o_alu_ctrl = ALU_ADD;
        endcase
    end

    // decode never emits class 7, so a valid instruction carrying it means
    // the decode stage and this table disagree.
    always_comb begin
        if (i_valid) begin
            assert (i_alu_op != OP_INVALID)
                else $error("alu_control: unused alu_op class on a valid instruction");
        end
    end

endmodule

// ==== execute/ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage (
    input  logic                i_clock,
    input  logic                i_reset,
    ex_ctrl_if.stage_in         ctrl_in,
    input  logic                i_branch,
    input  logic                i_alu_src,
    input  logic                i_reg_dst,
    input  mips_pkg::alu_op_t   i_alu_op,
    input  mips_pkg::data_t     i_pc,
    input  mips_pkg::data_t     i_fwd_a,
    input  mips_pkg::data_t     i_fwd_b,
    input  mips_pkg::data_t     i_immediate,
    input  mips_pkg::reg_addr_t i_rt,
    input  mips_pkg::reg_addr_t i_rd,
    ex_ctrl_if.stage_out        ctrl_out,
    output logic                o_branch,
    output mips_pkg::data_t     o_branch_address,
    output logic                o_zero,
    output mips_pkg::data_t     o_alu_result,
    output mips_pkg::data_t     o_store_data,
    output mips_pkg::reg_addr_t o_dest_reg
);

    import mips_pkg::*;

    alu_ctrl_e alu_ctrl;
    data_t     alu_b;
    data_t     alu_result;
    data_t     branch_address;
    reg_addr_t dest_reg;
    logic      zero;

    alu_control u_alu_control (
        .i_valid    (ctrl_in.valid),
        .i_alu_op   (i_alu_op),
        .i_funct    (funct_t'(i_immediate[NB_FUNCT-1:0])),
        .o_alu_ctrl (alu_ctrl)
    );

    assign alu_b = i_alu_src ? i_immediate : i_fwd_b;

    alu u_alu (
        .i_a        (i_fwd_a),
        .i_b        (alu_b),
        .i_shamt    (i_immediate[10:6]),
        .i_alu_ctrl (alu_ctrl),
        .o_result   (alu_result),
        .o_zero     (zero)
    );

    // pc already holds pc + 4, the offset counts words.
    assign branch_address = i_pc + {i_immediate[NB_DATA-3:0], 2'b00};
    assign dest_reg       = i_reg_dst ? i_rd : i_rt;

    // ex/mem pipeline register.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            ctrl_out.valid      <= 1'b0;
            ctrl_out.reg_write  <= 1'b0;
            ctrl_out.mem_to_reg <= 1'b0;
            ctrl_out.mem_read   <= 1'b0;
            ctrl_out.mem_write  <= 1'b0;
            o_branch            <= 1'b0;
            o_zero              <= 1'b0;
            o_branch_address    <= '0;
            o_alu_result        <= '0;
            o_store_data        <= '0;
            o_dest_reg          <= '0;
        end else begin
            // a bubble leaves no side effects in memory or the register file.
            ctrl_out.valid      <= ctrl_in.valid;
            ctrl_out.reg_write  <= ctrl_in.valid & ctrl_in.reg_write;
            ctrl_out.mem_to_reg <= ctrl_in.valid & ctrl_in.mem_to_reg;
            ctrl_out.mem_read   <= ctrl_in.valid & ctrl_in.mem_read;
            ctrl_out.mem_write  <= ctrl_in.valid & ctrl_in.mem_write;
            o_branch            <= ctrl_in.valid & i_branch;
            o_zero              <= zero;
            o_branch_address    <= branch_address;
            o_alu_result        <= alu_result;
            o_store_data        <= i_fwd_b;
            o_dest_reg          <= dest_reg;
        end
    end

    assert property (@(posedge i_clock) disable iff (i_reset)
        ctrl_out.valid |-> !(ctrl_out.mem_read && ctrl_out.mem_write))
        else $error("ex_stage: load and store flags both set on one instruction");

    assert property (@(posedge i_clock) disable iff (i_reset)
        !ctrl_out.valid |-> !(ctrl_out.reg_write || ctrl_out.mem_to_reg ||
                              ctrl_out.mem_read || ctrl_out.mem_write || o_branch))
        else $error("ex_stage: control flag set on an invalid slot");

endmodule

// ==== hdl/ex_top.sv ====
`timescale 1ns/1ns

module ex_top (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_valid,
    input  logic                i_reg_write,
    input  logic                i_mem_to_reg,
    input  logic                i_mem_read,
    input  logic                i_mem_write,
    input  logic                i_branch,
    input  logic                i_alu_src,
    input  logic                i_reg_dst,
    input  mips_pkg::alu_op_t   i_alu_op,
    input  mips_pkg::data_t     i_pc,
    input  mips_pkg::data_t     i_data_a,
    input  mips_pkg::data_t     i_data_b,
    input  mips_pkg::data_t     i_immediate,
    input  mips_pkg::reg_addr_t i_rs,
    input  mips_pkg::reg_addr_t i_rt,
    input  mips_pkg::reg_addr_t i_rd,
    output logic                o_valid,
    output logic                o_reg_write,
    output logic                o_mem_to_reg,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_branch,
    output mips_pkg::data_t     o_branch_address,
    output logic                o_zero,
    output mips_pkg::data_t     o_alu_result,
    output mips_pkg::data_t     o_store_data,
    output mips_pkg::reg_addr_t o_dest_reg
);

    import mips_pkg::*;

    data_t fwd_a;
    data_t fwd_b;

    ex_ctrl_if id_ctrl ();
    ex_ctrl_if mem_ctrl ();

    assign id_ctrl.valid      = i_valid;
    assign id_ctrl.reg_write  = i_reg_write;
    assign id_ctrl.mem_to_reg = i_mem_to_reg;
    assign id_ctrl.mem_read   = i_mem_read;
    assign id_ctrl.mem_write  = i_mem_write;

    // the forward unit looks at the ex/mem register, one slot ahead.
    forward_unit u_forward_unit (
        .i_rs         (i_rs),
        .i_rt         (i_rt),
        .i_data_a     (i_data_a),
        .i_data_b     (i_data_b),
        .i_mem_dest   (o_dest_reg),
        .i_mem_result (o_alu_result),
        .ctrl         (mem_ctrl.monitor),
        .o_fwd_a      (fwd_a),
        .o_fwd_b      (fwd_b)
    );

    ex_stage u_ex_stage (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .ctrl_in          (id_ctrl.stage_in),
        .i_branch         (i_branch),
        .i_alu_src        (i_alu_src),
        .i_reg_dst        (i_reg_dst),
        .i_alu_op         (i_alu_op),
        .i_pc             (i_pc),
        .i_fwd_a          (fwd_a),
        .i_fwd_b          (fwd_b),
        .i_immediate      (i_immediate),
        .i_rt             (i_rt),
        .i_rd             (i_rd),
        .ctrl_out         (mem_ctrl.stage_out),
        .o_branch         (o_branch),
        .o_branch_address (o_branch_address),
        .o_zero           (o_zero),
        .o_alu_result     (o_alu_result),
        .o_store_data     (o_store_data),
        .o_dest_reg       (o_dest_reg)
    );

    assign o_valid      = mem_ctrl.valid;
    assign o_reg_write  = mem_ctrl.reg_write;
    assign o_mem_to_reg = mem_ctrl.mem_to_reg;
    assign o_mem_read   = mem_ctrl.mem_read;
    assign o_mem_write  = mem_ctrl.mem_write;

endmodule

// ==== hdl/forward_unit.sv ====
`timescale 1ns/1ns

module forward_unit (
    input  mips_pkg::reg_addr_t i_rs,
    input  mips_pkg::reg_addr_t i_rt,
    input  mips_pkg::data_t     i_data_a,
    input  mips_pkg::data_t     i_data_b,
    input  mips_pkg::reg_addr_t i_mem_dest,
    input  mips_pkg::data_t     i_mem_result,
    ex_ctrl_if.monitor          ctrl,
    output mips_pkg::data_t     o_fwd_a,
    output mips_pkg::data_t     o_fwd_b
);

    import mips_pkg::*;

    logic mem_writes;
    logic hit_a;
    logic hit_b;

    // only the instruction one slot ahead is checked, older results are
    // already in the register file.
    assign mem_writes = ctrl.valid && ctrl.reg_write && (i_mem_dest != REG_ZERO);

    assign hit_a = mem_writes && (i_mem_dest == i_rs);
    assign hit_b = mem_writes && (i_mem_dest == i_rt);

    assign o_fwd_a = hit_a ? i_mem_result : i_data_a;
    assign o_fwd_b = hit_b ? i_mem_result : i_data_b;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_ex_top \
    -f build.f -o sim_ex_top \
    && ./obj_dir/sim_ex_top | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/ex_stim.txt ====
# name ctrl(valid,reg_write,mem_to_reg,mem_read,mem_write,branch,alu_src,reg_dst) alu_op pc a b imm rs rt rd
# expected: flags(valid,reg_write,mem_read,mem_write) alu_result zero branch_address store_data dest_reg
add_r        11000001 2 104 5        7        1820     1  2  3  1100 c        0 6184  7        3
sub_r        11000001 2 108 10       30       3022     4  5  6  1100 ffffffe0 0 c190  30       6
and_r        11000001 2 10c f0f0     ff00     4824     7  8  9  1100 f000     0 1219c ff00     9
or_r         11000001 2 110 f0f0     f0f      6025     10 11 12 1100 ffff     0 181a4 f0f      12
xor_r        11000001 2 114 ff00     ff0      7826     13 14 15 1100 f0f0     0 1e1ac ff0      15
nor_r        11000001 2 118 ffff0000 ff00     9027     16 17 18 1100 ff       0 241b4 ff00     18
slt_neg      11000001 2 11c fffffffb 3        a82a     19 20 21 1100 1        0 2a1c4 3        21
slt_pos      11000001 2 120 3        fffffffb c02a     22 23 24 1100 0        1 301c8 fffffffb 24
sll_r        11000001 2 124 0        3        d100     0  25 26 1100 30       0 34524 3        26
srl_r        11000001 2 128 0        80000000 e102     0  27 28 1100 8000000  0 38530 80000000 28
fwd_rs       11000001 2 12c 11111111 1        1820     28 2  3  1100 8000001  0 61ac  1        3
fwd_rt       11000001 2 130 10000000 22222222 2022     1  3  4  1100 7ffffff  0 81b8  8000001  4
fwd_both     11000001 2 134 33333333 33333333 2820     4  4  5  1100 ffffffe  0 a1b4  7ffffff  5
sw_fwd_rt    10001010 0 138 1000     44444444 8        6  5  0  1001 1008     0 158   ffffffe  5
lw_no_fwd    11110010 0 13c 2000     44       fffffffc 5  7  0  1110 1ffc     0 12c   44       7
bubble       00000000 0 0   0        0        0        0  0  0  0000 0        1 0     0        0
andi_bubble  11000010 3 140 12345678 55       ff0f     7  8  0  1100 5608     0 3fd7c 55       8
ori_fwd      11000010 4 144 99       66       f0       8  9  0  1100 56f8     0 504   66       9
slti_neg     11000010 5 148 fffffff0 0        fffffff8 10 11 0  1100 1        0 128   0        11
lui          11000010 6 14c 0        0        1234     0  12 0  1100 12340000 0 4a1c  0        12
beq_eq       10000100 1 150 77       77       10       13 14 0  1000 0        1 190   77       14
beq_ne       10000100 1 154 77       78       fffffffe 13 14 0  1000 ffffffff 0 14c   78       14
write_r0     11000001 2 158 5        6        20       1  2  0  1100 b        0 1d8   6        0
no_fwd_r0    11000001 2 15c 0        0        1820     0  0  3  1100 0        1 61dc  0        3
bubble_flags 01110100 0 0   0        0        0        0  0  0  0000 0        1 0     0        0

// ==== tests/tb_ex_top.sv ====
`timescale 1ns/1ns

module tb_ex_top;

    import mips_pkg::*;

    localparam int MAX_TESTS  = 64;
    localparam int CLK_PERIOD = 20;

    logic      i_clock, i_reset, i_valid, i_reg_write, i_mem_to_reg, i_mem_read;
    logic      i_mem_write, i_branch, i_alu_src, i_reg_dst;
    alu_op_t   i_alu_op;
    data_t     i_pc, i_data_a, i_data_b, i_immediate;
    reg_addr_t i_rs, i_rt, i_rd;
    logic      o_valid, o_reg_write, o_mem_to_reg, o_mem_read, o_mem_write, o_branch, o_zero;
    data_t     o_branch_address, o_alu_result, o_store_data;
    reg_addr_t o_dest_reg;

    // ctrl holds valid down to reg_dst, flags holds the expected valid,
    // reg_write, mem_read and mem_write.
    string      name_v  [MAX_TESTS];
    logic [7:0] ctrl_v  [MAX_TESTS];
    logic [3:0] flags_v [MAX_TESTS];
    alu_op_t    op_v    [MAX_TESTS];
    data_t      pc_v [MAX_TESTS], a_v [MAX_TESTS], b_v [MAX_TESTS], imm_v [MAX_TESTS];
    data_t      result_v [MAX_TESTS], baddr_v [MAX_TESTS], store_v [MAX_TESTS];
    reg_addr_t  rs_v [MAX_TESTS], rt_v [MAX_TESTS], rd_v [MAX_TESTS], dest_v [MAX_TESTS];
    logic       zero_v  [MAX_TESTS];

    int   num_tests   = 0;
    int   errors      = 0;
    int   test_errors = 0;
    int   passed      = 0;
    int   failed      = 0;
    logic loaded      = 1'b0;

    ex_top u_dut (.*);

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    task automatic check_data(input string test, input string field,
                              input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("Error %0s %0s expected %h actual %h", test, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_reg(input string test, input string field,
                             input reg_addr_t expected, input reg_addr_t actual);
        if (actual !== expected) begin
            $display("Error %0s %0s expected %0d actual %0d", test, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string test, input string field,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error %0s %0s expected %b actual %b", test, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        int    count;
        string line;
        fd = $fopen("tests/ex_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tests/ex_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            if (num_tests == MAX_TESTS) begin
                $display("the stimulus file holds more lines than the testbench can store");
                errors++;
                break;
            end
            count = $sscanf(line, "%s %b %d %h %h %h %h %d %d %d %b %h %b %h %h %d",
                            name_v[num_tests], ctrl_v[num_tests], op_v[num_tests],
                            pc_v[num_tests], a_v[num_tests], b_v[num_tests],
                            imm_v[num_tests], rs_v[num_tests], rt_v[num_tests],
                            rd_v[num_tests], flags_v[num_tests], result_v[num_tests],
                            zero_v[num_tests], baddr_v[num_tests], store_v[num_tests],
                            dest_v[num_tests]);
            if (count != 16) begin
                $display("a stimulus line could not be parsed: %0s", line);
                errors++;
            end else begin
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_line(input int i);
        {i_valid, i_reg_write, i_mem_to_reg, i_mem_read} <= ctrl_v[i][7:4];
        {i_mem_write, i_branch, i_alu_src, i_reg_dst}    <= ctrl_v[i][3:0];
        i_alu_op    <= op_v[i];
        i_pc        <= pc_v[i];
        i_data_a    <= a_v[i];
        i_data_b    <= b_v[i];
        i_immediate <= imm_v[i];
        i_rs        <= rs_v[i];
        i_rt        <= rt_v[i];
        i_rd        <= rd_v[i];
    endtask

    task automatic apply_bubble();
        {i_valid, i_reg_write, i_mem_to_reg, i_mem_read} <= 4'b0000;
        {i_mem_write, i_branch, i_alu_src, i_reg_dst}    <= 4'b0000;
        i_alu_op    <= '0;
        i_pc        <= '0;
        i_data_a    <= '0;
        i_data_b    <= '0;
        i_immediate <= '0;
        {i_rs, i_rt, i_rd} <= '0;
    endtask

    task automatic report_test(input string test);
        if (test_errors == 0) begin
            $display("pass %0s", test);
            passed++;
        end else begin
            $display("fail %0s with %0d mismatches", test, test_errors);
            failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic verify_reset();
        check_flag("reset", "o_valid", 1'b0, o_valid);
        check_flag("reset", "o_reg_write", 1'b0, o_reg_write);
        check_flag("reset", "o_mem_to_reg", 1'b0, o_mem_to_reg);
        check_flag("reset", "o_mem_read", 1'b0, o_mem_read);
        check_flag("reset", "o_mem_write", 1'b0, o_mem_write);
        check_flag("reset", "o_branch", 1'b0, o_branch);
        check_flag("reset", "o_zero", 1'b0, o_zero);
        check_data("reset", "o_branch_address", '0, o_branch_address);
        check_data("reset", "o_alu_result", '0, o_alu_result);
        check_data("reset", "o_store_data", '0, o_store_data);
        check_reg("reset", "o_dest_reg", '0, o_dest_reg);
        report_test("reset");
    endtask

    task automatic verify_line(input int i);
        logic exp_mem_to_reg;
        logic exp_branch;
        // mem_to_reg and branch travel on unchanged for a valid slot and drop on a bubble.
        exp_mem_to_reg = flags_v[i][3] ? ctrl_v[i][5] : 1'b0;
        exp_branch     = flags_v[i][3] ? ctrl_v[i][2] : 1'b0;
        check_flag(name_v[i], "o_valid", flags_v[i][3], o_valid);
        check_flag(name_v[i], "o_reg_write", flags_v[i][2], o_reg_write);
        check_flag(name_v[i], "o_mem_to_reg", exp_mem_to_reg, o_mem_to_reg);
        check_flag(name_v[i], "o_mem_read", flags_v[i][1], o_mem_read);
        check_flag(name_v[i], "o_mem_write", flags_v[i][0], o_mem_write);
        check_flag(name_v[i], "o_branch", exp_branch, o_branch);
        check_data(name_v[i], "o_alu_result", result_v[i], o_alu_result);
        check_flag(name_v[i], "o_zero", zero_v[i], o_zero);
        check_data(name_v[i], "o_branch_address", baddr_v[i], o_branch_address);
        check_data(name_v[i], "o_store_data", store_v[i], o_store_data);
        check_reg(name_v[i], "o_dest_reg", dest_v[i], o_dest_reg);
        report_test(name_v[i]);
    endtask

    // the run length follows from the number of stimulus lines.
    initial begin
        wait (loaded);
        #((num_tests + 20) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in the expected time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        i_reset = 1'b1;
        apply_bubble();
        read_stimulus();
        loaded = 1'b1;
        repeat (8) @(posedge i_clock);
        i_reset <= 1'b0;
        @(negedge i_clock);
        verify_reset();
        // outputs of line i are checked while line i + 1 is being presented.
        for (int i = 0; i <= num_tests; i++) begin
            @(posedge i_clock);
            if (i < num_tests)
                apply_line(i);
            else
                apply_bubble();
            if (i > 0) begin
                @(negedge i_clock);
                verify_line(i - 1);
            end
        end
        if (num_tests == 0) begin
            $display("no stimulus lines were read");
            errors++;
        end
        $display("tests %0d passed %0d failed %0d mismatches %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
